// File: src/dqmPkg.sv
package dqmPkg;

    // Frame header layout: sync, zero pad, version, dqm value
    localparam logic [15:0] dqmSyncWord = 16'hEB90;
    localparam logic [3:0] framerVersion = 4'd1;
    localparam int headerBits = 48;
    localparam int dqmWidth = 16;

    // Payload limits
    localparam int maxPayloadBits = 256;
    localparam int payloadSizeBits = $clog2(maxPayloadBits + 1);

    // Bit FIFO holds two maximum payloads; also the source's starting credit count
    localparam int fifoDepth = 512;
    localparam int fifoAddrBits = $clog2(fifoDepth);
    localparam int fifoCountBits = $clog2(fifoDepth + 1);

    // Output bit-rate divider
    localparam int clkDivBits = 16;

    typedef enum logic [1:0] {
        stateIdle,
        stateHeader,
        statePayload
    } frameState;

endpackage

// File: src/payloadIngress.sv
`timescale 1ns/10ps

module payloadIngress (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                payloadBitEn,
    input  logic                                payloadBit,
    input  logic                                readStrobe,
    input  logic [dqmPkg::payloadSizeBits-1:0]  payloadSize,
    output logic                                headBit,
    output logic [dqmPkg::fifoCountBits-1:0]    fifoCount,
    output logic                                creditReturn,
    output logic                                dqmStartOfFrame
);

    import dqmPkg::*;

    logic                       fifoMem [fifoDepth];
    logic [fifoAddrBits-1:0]    wrPtr;
    logic [fifoAddrBits-1:0]    rdPtr;
    logic [payloadSizeBits-1:0] boundaryCount;

    // Storage only, pointers carry the state
    always_ff @(posedge clk) begin
        if (payloadBitEn) begin
            fifoMem[wrPtr] <= payloadBit;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (payloadBitEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (readStrobe) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fifoCount <= '0;
        end else begin
            case ({payloadBitEn, readStrobe})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
        end
    end

    assign headBit = fifoMem[rdPtr];

    // One credit goes back to the source for each popped bit
    always_ff @(posedge clk) begin
        if (reset) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= readStrobe;
        end
    end

    // Input-side frame boundary, zero right after every payloadSize-th bit
    always_ff @(posedge clk) begin
        if (reset) begin
            boundaryCount <= '0;
        end else if (payloadBitEn) begin
            if (boundaryCount == '0) begin
                boundaryCount <= payloadSize - 1'b1;
            end else begin
                boundaryCount <= boundaryCount - 1'b1;
            end
        end
    end

    assign dqmStartOfFrame = (boundaryCount == '0);

    // Source must respect its credits
    noWriteWhenFull: assert property (@(posedge clk) disable iff (reset)
        payloadBitEn |-> fifoCount < fifoCountBits'(fifoDepth));

    // Builder only reads once a full payload is buffered
    noReadWhenEmpty: assert property (@(posedge clk) disable iff (reset)
        readStrobe |-> fifoCount != '0);

endmodule

// File: src/frameBuilder.sv
`timescale 1ns/10ps

module frameBuilder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                bitTick,
    input  logic [dqmPkg::fifoCountBits-1:0]    fifoCount,
    input  logic                                headBit,
    input  logic [dqmPkg::dqmWidth-1:0]         dqm,
    input  logic [dqmPkg::payloadSizeBits-1:0]  payloadSize,
    output logic                                readStrobe,
    output logic                                txBit,
    output logic                                txValid
);

    import dqmPkg::*;

    frameState                  state;
    logic [headerBits-1:0]      headerSr;
    logic [payloadSizeBits-1:0] bitCount;
    logic                       payloadReady;

    // Wait for a whole payload so the FIFO cannot run dry mid-frame
    assign payloadReady = (fifoCount >= fifoCountBits'(payloadSize));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stateIdle;
            bitCount <= '0;
        end else if (bitTick) begin
            case (state)
                stateIdle: begin
                    if (payloadReady) begin
                        bitCount <= payloadSizeBits'(headerBits - 1);
                        state    <= stateHeader;
                    end
                end
                stateHeader: begin
                    if (bitCount == '0) begin
                        bitCount <= payloadSize - 1'b1;
                        state    <= statePayload;
                    end else begin
                        bitCount <= bitCount - 1'b1;
                    end
                end
                statePayload: begin
                    if (bitCount == '0) begin
                        state <= stateIdle;
                    end else begin
                        bitCount <= bitCount - 1'b1;
                    end
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    // Header register, loaded at frame start and shifted out MSB first
    always_ff @(posedge clk) begin
        if (bitTick) begin
            if (state == stateIdle && payloadReady) begin
                headerSr <= {dqmSyncWord, 12'b0, framerVersion, dqm};
            end else if (state == stateHeader) begin
                headerSr <= {headerSr[headerBits-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        case (state)
            stateHeader: begin
                txBit   = headerSr[headerBits-1];
                txValid = 1'b1;
            end
            statePayload: begin
                txBit   = headBit;
                txValid = 1'b1;
            end
            default: begin
                txBit   = 1'b0;
                txValid = 1'b0;
            end
        endcase
    end

    // Pop the FIFO on the tick that sends its head bit
    assign readStrobe = bitTick && (state == statePayload);

    // Every payload bit still to be sent is already in the FIFO
    payloadBuffered: assert property (@(posedge clk) disable iff (reset)
        readStrobe |-> fifoCount > fifoCountBits'(bitCount));

    payloadSizeInRange: assert property (@(posedge clk) disable iff (reset)
        payloadSize <= payloadSizeBits'(maxPayloadBits));

endmodule

// File: src/bitPacer.sv
`timescale 1ns/10ps

module bitPacer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [dqmPkg::clkDivBits-1:0]   clksPerBit,
    input  logic                            txBit,
    input  logic                            txValid,
    output logic                            bitTick,
    output logic                            dqmBit,
    output logic                            dqmBitEn
);

    import dqmPkg::*;

    logic [clkDivBits-1:0] divCount;

    // Tick at zero, then reload, so one tick every clksPerBit+1 clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
        end else if (divCount == '0) begin
            divCount <= clksPerBit;
        end else begin
            divCount <= divCount - 1'b1;
        end
    end

    assign bitTick = (divCount == '0);

    always_ff @(posedge clk) begin
        if (bitTick) begin
            dqmBit <= txBit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dqmBitEn <= 1'b0;
        end else begin
            dqmBitEn <= bitTick && txValid;
        end
    end

    // Back-to-back strobes only at the full clock rate
    enableSpacing: assert property (@(posedge clk) disable iff (reset)
        dqmBitEn && clksPerBit != '0 |=> !dqmBitEn);

endmodule

// File: src/dqmFramerTop.sv
`timescale 1ns/10ps

module dqmFramerTop (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                payloadBitEn,
    input  logic                                payloadBit,
    input  logic [dqmPkg::dqmWidth-1:0]         dqm,
    input  logic [dqmPkg::payloadSizeBits-1:0]  payloadSize,
    input  logic [dqmPkg::clkDivBits-1:0]       clksPerBit,
    output logic                                creditReturn,
    output logic                                dqmStartOfFrame,
    output logic                                dqmBit,
    output logic                                dqmBitEn
);

    import dqmPkg::*;

    logic                       headBit;
    logic [fifoCountBits-1:0]   fifoCount;
    logic                       readStrobe;
    logic                       bitTick;
    logic                       txBit;
    logic                       txValid;

    payloadIngress payloadIngress_i (
        .clk             (clk),
        .reset           (reset),
        .payloadBitEn    (payloadBitEn),
        .payloadBit      (payloadBit),
        .readStrobe      (readStrobe),
        .payloadSize     (payloadSize),
        .headBit         (headBit),
        .fifoCount       (fifoCount),
        .creditReturn    (creditReturn),
        .dqmStartOfFrame (dqmStartOfFrame)
    );

    frameBuilder frameBuilder_i (
        .clk         (clk),
        .reset       (reset),
        .bitTick     (bitTick),
        .fifoCount   (fifoCount),
        .headBit     (headBit),
        .dqm         (dqm),
        .payloadSize (payloadSize),
        .readStrobe  (readStrobe),
        .txBit       (txBit),
        .txValid     (txValid)
    );

    bitPacer bitPacer_i (
        .clk        (clk),
        .reset      (reset),
        .clksPerBit (clksPerBit),
        .txBit      (txBit),
        .txValid    (txValid),
        .bitTick    (bitTick),
        .dqmBit     (dqmBit),
        .dqmBitEn   (dqmBitEn)
    );

endmodule

// File: test/dqmFramerTb.sv
`timescale 1ns/10ps

module dqmFramerTb;

    import dqmPkg::*;

    logic                       clk;
    logic                       reset;
    logic                       payloadBitEn;
    logic                       payloadBit;
    logic [dqmWidth-1:0]        dqm;
    logic [payloadSizeBits-1:0] payloadSize;
    logic [clkDivBits-1:0]      clksPerBit;
    logic                       creditReturn;
    logic                       dqmStartOfFrame;
    logic                       dqmBit;
    logic                       dqmBitEn;

    // Test table
    int            testPayload [3] = '{16, 200, 256};
    int            testClks [3] = '{0, 3, 1};
    logic [15:0]   testDqm [3] = '{16'h3A5C, 16'hC0DE, 16'h7E11};

    integer        seed;
    int            errorCount = 0;
    int            testsFailed = 0;
    int            cycleCount = 0;
    int            credits = fifoDepth;
    int            creditsReturned = 0;
    int            payloadSent = 0;
    int            pulseCount = 0;
    int            framesDone = 0;
    int            frameIndex = 0;
    int            sinceBoundary = 0;
    int            lastEnCycle = 0;
    int            curPayloadSize = 16;
    int            curClksPerBit = 0;
    logic [15:0]   curDqm = '0;
    logic          resetSeen = 1'b0;
    logic          acceptQueue [$];
    logic [headerBits-1:0] expHeader;

    dqmFramerTop dqmFramerTop_i (
        .clk             (clk),
        .reset           (reset),
        .payloadBitEn    (payloadBitEn),
        .payloadBit      (payloadBit),
        .dqm             (dqm),
        .payloadSize     (payloadSize),
        .clksPerBit      (clksPerBit),
        .creditReturn    (creditReturn),
        .dqmStartOfFrame (dqmStartOfFrame),
        .dqmBit          (dqmBit),
        .dqmBitEn        (dqmBitEn)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Worst case per test is three frames at the programmed rate plus fill and drain
    function automatic int timeoutCycles();
        int total;
        int i;
        total = 0;
        for (i = 0; i < 3; i++) begin
            total += 3 * ((headerBits + testPayload[i]) * (testClks[i] + 1) + 4 * testPayload[i]);
            total += 4 * (testClks[i] + 1) + 8;
        end
        return (total * 3) / 2 + 16;
    endfunction

    resetQuiet: assert property (@(posedge clk) reset && resetSeen |-> !dqmBitEn && !creditReturn)
        else begin
            errorCount++;
            $display("dqmBitEn or creditReturn went high during reset at %0t", $time);
        end

    creditsInRange: assert property (@(posedge clk) disable iff (reset)
        credits >= 0 && credits <= fifoDepth)
        else begin
            errorCount++;
            $display("Source credit count %0d left its legal range at %0t", credits, $time);
        end

    // Reference model for accepted bits, credits and the serial frame
    always @(posedge clk) begin : scoreboard
        logic expBit;
        cycleCount++;
        if (reset) begin
            resetSeen <= 1'b1;
        end else begin
            assert (dqmStartOfFrame === (sinceBoundary == 0)) else begin
                errorCount++;
                $display("Mismatch at %0t: dqmStartOfFrame expected %0b actual %0b",
                    $time, sinceBoundary == 0, dqmStartOfFrame);
            end
            if (creditReturn) begin
                credits++;
                creditsReturned++;
            end
            if (dqmBitEn) begin
                pulseCount++;
                expBit = 1'b0;
                if (frameIndex == 0) begin
                    expHeader = {dqmSyncWord, 12'b0, framerVersion, curDqm};
                    assert (acceptQueue.size() >= curPayloadSize) else begin
                        errorCount++;
                        $display("Frame started at %0t before a full payload was accepted", $time);
                    end
                end else begin
                    assert (cycleCount - lastEnCycle == curClksPerBit + 1) else begin
                        errorCount++;
                        $display("Mismatch at %0t: dqmBitEn spacing expected %0d actual %0d",
                            $time, curClksPerBit + 1, cycleCount - lastEnCycle);
                    end
                end
                lastEnCycle = cycleCount;
                if (frameIndex < headerBits) begin
                    expBit = expHeader[headerBits-1];
                    expHeader = expHeader << 1;
                end else begin
                    assert (acceptQueue.size() != 0) else begin
                        errorCount++;
                        $display("Payload bit sent at %0t with no accepted source bit left", $time);
                    end
                    if (acceptQueue.size() != 0) begin
                        expBit = acceptQueue.pop_front();
                    end
                    payloadSent++;
                end
                assert (dqmBit === expBit) else begin
                    errorCount++;
                    $display("Mismatch at %0t: dqmBit expected %0b actual %0b (frame bit %0d)",
                        $time, expBit, dqmBit, frameIndex);
                end
                frameIndex++;
                if (frameIndex == headerBits + curPayloadSize) begin
                    frameIndex = 0;
                    framesDone++;
                end
            end
            if (payloadBitEn) begin
                credits--;
                acceptQueue.push_back(payloadBit);
                sinceBoundary++;
                if (sinceBoundary == curPayloadSize) begin
                    sinceBoundary = 0;
                end
            end
        end
    end

    // Source sends exactly three payloads, then waits for the frames to drain
    task automatic runTest(input int n);
        int ps;
        int sent;
        int coin;
        int framesAtStart;
        int pulsesAtDone;
        int errorsBefore;
        ps = testPayload[n];
        sent = 0;
        errorsBefore = errorCount;
        framesAtStart = framesDone;
        @(posedge clk);
        #1;
        payloadSize = payloadSizeBits'(ps);
        clksPerBit = clkDivBits'(testClks[n]);
        dqm = testDqm[n];
        curPayloadSize = ps;
        curClksPerBit = testClks[n];
        curDqm = testDqm[n];
        while (framesDone < framesAtStart + 3) begin
            @(posedge clk);
            #1;
            coin = $random(seed);
            if (sent < 3 * ps && credits > 0 && coin[0]) begin
                payloadBitEn = 1'b1;
                payloadBit = coin[1];
                sent++;
            end else begin
                payloadBitEn = 1'b0;
            end
        end
        pulsesAtDone = pulseCount;
        repeat (4 * (testClks[n] + 1) + 4) @(posedge clk);
        #1;
        assert (pulseCount == pulsesAtDone) else begin
            errorCount++;
            $display("dqmBitEn kept pulsing after the third frame of test %0d", n);
        end
        assert (acceptQueue.size() == 0) else begin
            errorCount++;
            $display("%0d accepted source bits were never sent in test %0d",
                acceptQueue.size(), n);
        end
        assert (credits == fifoDepth) else begin
            errorCount++;
            $display("Mismatch at %0t: credits expected %0d actual %0d",
                $time, fifoDepth, credits);
        end
        assert (creditsReturned == payloadSent) else begin
            errorCount++;
            $display("Mismatch at %0t: creditReturn total expected %0d actual %0d",
                $time, payloadSent, creditsReturned);
        end
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("Test %0d payloadSize %0d clksPerBit %0d dqm %h: %s", n, ps, testClks[n],
            testDqm[n], (errorCount == errorsBefore) ? "ok" : "FAILED");
    endtask

    initial begin : stimulus
        int t;
        seed = 32'hf8489545;
        reset = 1'b1;
        payloadBitEn = 1'b0;
        payloadBit = 1'b0;
        dqm = '0;
        payloadSize = payloadSizeBits'(16);
        clksPerBit = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (t = 0; t < 3; t++) begin
            runTest(t);
        end
        $display("Tests run 3, tests failed %0d, errors %0d", testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = timeoutCycles();
        while (cycleCount < limit) begin
            @(posedge clk);
        end
        $display("Timeout: run stopped after %0d cycles without finishing", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: dqmFramerTop.f
src/dqmPkg.sv
src/payloadIngress.sv
src/frameBuilder.sv
src/bitPacer.sv
src/dqmFramerTop.sv
test/dqmFramerTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the DQM framer regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dqmFramerTb -f dqmFramerTop.f -o simDqmFramer \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simDqmFramer > sim.log 2>&1
cat sim.log
# The log decides the result, not the simulator's exit status
grep -qx "Regression passed" sim.log && exit 0 || exit 1
